// ==== Bender.yml ====
package:
  name: tawas

sources:
  # Core RTL, packages first
  - target: rtl
    files:
      - hdl/tawas_isa_pkg.sv
      - hdl/tawas_bus_pkg.sv
      - hdl/tawas_fetch.sv
      - hdl/tawas_regfile.sv
      - hdl/tawas_au.sv
      - hdl/tawas_ls.sv
      - hdl/tawas.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tb/tawas_asserts.sv
      - tb/tawas_tb.sv

// ==== compile.f ====
hdl/tawas_isa_pkg.sv
hdl/tawas_bus_pkg.sv
hdl/tawas_fetch.sv
hdl/tawas_regfile.sv
hdl/tawas_au.sv
hdl/tawas_ls.sv
hdl/tawas.sv
tb/tawas_asserts.sv
tb/tawas_tb.sv

// ==== hdl/tawas.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tawas core top level
// Four-slice barrel RISC core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tawas (
    input  logic                  clk,
    input  logic                  arst_n,

    output logic                  ics,
    output tawas_bus_pkg::iaddr_t iaddr,
    input  tawas_isa_pkg::word_t  idata,

    output logic                  dcs,
    output logic                  dwr,
    output logic [3:0]            dmask,
    output tawas_bus_pkg::daddr_t daddr,
    output tawas_isa_pkg::word_t  dout,
    input  tawas_isa_pkg::word_t  din
);
    import tawas_isa_pkg::*;
    import tawas_bus_pkg::*;

    slice_t   slice;
    slice_t   exec_slice;

    logic     pc_store;
    iaddr_t   pc_out;
    iaddr_t   pc_rtn;
    flags_t   au_flags;

    logic     au_op_vld;
    logic     ls_op_vld;
    opcode_t  op;
    reg_sel_t rc_sel;
    reg_sel_t ra_sel;
    reg_sel_t rb_sel;
    imm_t     imm;
    word_t    ra;
    word_t    rb;

    logic     au_rc_vld;
    reg_sel_t au_rc_sel;
    word_t    au_rc;
    logic     au_flags_upd;
    flags_t   au_flags_in;

    logic     ls_load_vld;
    slice_t   ls_load_slice;
    reg_sel_t ls_load_sel;
    word_t    ls_load;

    tawas_fetch tawas_fetch (.*);

    tawas_regfile tawas_regfile (
        .pc_in(pc_out),
        .*
    );

    tawas_au tawas_au (.*);

    tawas_ls tawas_ls (.*);

endmodule

`default_nettype wire

// ==== hdl/tawas_au.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tawas arithmetic unit
// ALU ops with zero and carry flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tawas_au (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    au_op_vld,
    input  tawas_isa_pkg::opcode_t  op,
    input  tawas_isa_pkg::reg_sel_t rc_sel,
    input  tawas_isa_pkg::word_t    ra,
    input  tawas_isa_pkg::word_t    rb,
    input  tawas_isa_pkg::imm_t     imm,
    input  tawas_isa_pkg::flags_t   au_flags,

    output logic                    au_rc_vld,
    output tawas_isa_pkg::reg_sel_t au_rc_sel,
    output tawas_isa_pkg::word_t    au_rc,
    output logic                    au_flags_upd,
    output tawas_isa_pkg::flags_t   au_flags_in
);
    import tawas_isa_pkg::*;

    logic [$bits(word_t):0] wide;  // Carry out in the top bit
    word_t                  result;
    logic                   carry;

    always_comb begin
        wide = '0;
        result = ra;
        carry = au_flags[FLAG_C];  // Kept unless ADD or SUB
        case (op)
            ADD: begin
                wide = {1'b0, ra} + {1'b0, rb};
                result = wide[31:0];
                carry = wide[32];
            end
            SUB: begin
                wide = {1'b0, ra} - {1'b0, rb};
                result = wide[31:0];
                carry = wide[32];  // Borrow
            end
            AND: result = ra & rb;
            OR:  result = ra | rb;
            XOR: result = ra ^ rb;
            SHL: result = ra << rb[4:0];
            SHR: result = ra >> rb[4:0];
            LDI: result = {{16{imm[15]}}, imm};
            default: ;
        endcase
    end

    assign au_rc_vld = au_op_vld;
    assign au_rc_sel = rc_sel;
    assign au_rc = result;

    // LDI leaves the flags alone
    assign au_flags_upd = au_op_vld && (op != LDI);
    assign au_flags_in[FLAG_Z] = (result == '0);
    assign au_flags_in[FLAG_C] = carry;

endmodule

`default_nettype wire

// ==== hdl/tawas_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tawas memory ports
// Address types and reset PC layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package tawas_bus_pkg;

    typedef logic [23:0] iaddr_t;  // Instruction word address
    typedef logic [31:0] daddr_t;  // Data byte address

    // Slice n starts at n * stride
    localparam iaddr_t SLICE_PC_STRIDE = 24'd64;

endpackage

`default_nettype wire

// ==== hdl/tawas_fetch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tawas fetch and decode
// Slice rotation, instruction request, branches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tawas_fetch (
    input  logic                   clk,
    input  logic                   arst_n,

    output logic                   ics,
    output tawas_bus_pkg::iaddr_t  iaddr,
    input  tawas_isa_pkg::word_t   idata,

    input  tawas_bus_pkg::iaddr_t  pc_rtn,
    input  tawas_isa_pkg::flags_t  au_flags,

    output tawas_isa_pkg::slice_t  slice,
    output tawas_isa_pkg::slice_t  exec_slice,

    output logic                   pc_store,
    output tawas_bus_pkg::iaddr_t  pc_out,

    output logic                   au_op_vld,
    output logic                   ls_op_vld,
    output tawas_isa_pkg::opcode_t op,
    output tawas_isa_pkg::reg_sel_t rc_sel,
    output tawas_isa_pkg::reg_sel_t ra_sel,
    output tawas_isa_pkg::reg_sel_t rb_sel,
    output tawas_isa_pkg::imm_t    imm
);
    import tawas_isa_pkg::*;
    import tawas_bus_pkg::*;

    logic                  run;
    logic [NUM_SLICES-1:0] halted;
    logic                  exec_vld;  // idata holds a fetched word this cycle
    iaddr_t                exec_pc;
    iaddr_t                br_target;
    logic                  br_taken;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
            slice <= '0;
            exec_slice <= '0;
            exec_vld <= 1'b0;
            halted <= '0;
        end else begin
            run <= 1'b1;
            slice <= slice + 1'b1;  // Wraps after the last slice
            exec_slice <= slice;
            exec_vld <= ics;
            if (exec_vld && (op == HALT))
                halted[exec_slice] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        exec_pc <= iaddr;
    end

    assign ics = run && !halted[slice];
    assign iaddr = pc_rtn;

    // Decode
    assign op = opcode_t'(idata[OP_MSB:OP_LSB]);
    assign rc_sel = idata[RC_MSB:RC_LSB];
    assign ra_sel = idata[RA_MSB:RA_LSB];
    assign rb_sel = idata[RB_MSB:RB_LSB];
    assign imm = idata[IMM_MSB:IMM_LSB];

    always_comb begin
        au_op_vld = 1'b0;
        ls_op_vld = 1'b0;
        br_taken = 1'b0;
        if (exec_vld) begin
            case (op)
                ADD, SUB, AND, OR, XOR, SHL, SHR, LDI: au_op_vld = 1'b1;
                LD, ST:  ls_op_vld = 1'b1;
                BZ:      br_taken = au_flags[FLAG_Z];
                BNZ:     br_taken = !au_flags[FLAG_Z];
                JMP:     br_taken = 1'b1;
                default: ;
            endcase
        end
    end

    assign br_target = {{8{imm[15]}}, imm};

    // A halted slice keeps its PC
    assign pc_store = exec_vld && (op != HALT);
    assign pc_out = br_taken ? br_target : exec_pc + 1'b1;

endmodule

`default_nettype wire

// ==== hdl/tawas_isa_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tawas instruction set
// Field types, opcodes, register and slice counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package tawas_isa_pkg;

    localparam int NUM_SLICES = 4;
    localparam int NUM_REGS = 8;

    typedef logic [$clog2(NUM_SLICES)-1:0] slice_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_sel_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] imm_t;
    typedef logic [1:0] flags_t;

    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;

    // ALU ops: rc = ra op rb, LDI: rc = sext(imm)
    // LD: rc = mem[ra + sext(imm)], ST: mem[ra + sext(imm)] = rb
    // BZ/BNZ/JMP jump to sext(imm) as a word address
    typedef enum logic [3:0] {
        NOP  = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        AND  = 4'h3,
        OR   = 4'h4,
        XOR  = 4'h5,
        SHL  = 4'h6,
        SHR  = 4'h7,
        LDI  = 4'h8,
        LD   = 4'h9,
        ST   = 4'ha,
        BZ   = 4'hb,
        BNZ  = 4'hc,
        JMP  = 4'hd,
        HALT = 4'he
    } opcode_t;

    // Instruction word fields
    localparam int OP_MSB = 31;
    localparam int OP_LSB = 28;
    localparam int RC_MSB = 27;
    localparam int RC_LSB = 25;
    localparam int RA_MSB = 24;
    localparam int RA_LSB = 22;
    localparam int RB_MSB = 21;
    localparam int RB_LSB = 19;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;

endpackage

`default_nettype wire

// ==== hdl/tawas_ls.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tawas load/store unit
// Word accesses on the data port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tawas_ls (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    ls_op_vld,
    input  tawas_isa_pkg::opcode_t  op,
    input  tawas_isa_pkg::slice_t   exec_slice,
    input  tawas_isa_pkg::reg_sel_t rc_sel,
    input  tawas_isa_pkg::word_t    ra,
    input  tawas_isa_pkg::word_t    rb,
    input  tawas_isa_pkg::imm_t     imm,

    output logic                    dcs,
    output logic                    dwr,
    output logic [3:0]              dmask,
    output tawas_bus_pkg::daddr_t   daddr,
    output tawas_isa_pkg::word_t    dout,
    input  tawas_isa_pkg::word_t    din,

    output logic                    ls_load_vld,
    output tawas_isa_pkg::slice_t   ls_load_slice,
    output tawas_isa_pkg::reg_sel_t ls_load_sel,
    output tawas_isa_pkg::word_t    ls_load
);
    import tawas_isa_pkg::*;
    import tawas_bus_pkg::*;

    logic is_load;

    assign is_load = ls_op_vld && (op == LD);

    assign dcs = ls_op_vld;
    assign dwr = ls_op_vld && (op == ST);
    assign dmask = 4'hf;  // Word accesses only
    assign daddr = daddr_t'(ra) + daddr_t'({{16{imm[15]}}, imm});
    assign dout = rb;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            ls_load_vld <= 1'b0;
        else
            ls_load_vld <= is_load;
    end

    // Destination of the pending load
    always_ff @(posedge clk) begin
        if (is_load) begin
            ls_load_slice <= exec_slice;
            ls_load_sel <= rc_sel;
        end
    end

    assign ls_load = din;

endmodule

`default_nettype wire

// ==== hdl/tawas_regfile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tawas register file
// Registers, PC and flags per slice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tawas_regfile (
    input  logic                    clk,
    input  logic                    arst_n,

    input  tawas_isa_pkg::slice_t   slice,
    input  tawas_isa_pkg::slice_t   exec_slice,

    input  logic                    pc_store,
    input  tawas_bus_pkg::iaddr_t   pc_in,
    output tawas_bus_pkg::iaddr_t   pc_rtn,

    input  logic                    au_flags_upd,
    input  tawas_isa_pkg::flags_t   au_flags_in,
    output tawas_isa_pkg::flags_t   au_flags,

    input  tawas_isa_pkg::reg_sel_t ra_sel,
    output tawas_isa_pkg::word_t    ra,
    input  tawas_isa_pkg::reg_sel_t rb_sel,
    output tawas_isa_pkg::word_t    rb,

    input  logic                    au_rc_vld,
    input  tawas_isa_pkg::reg_sel_t au_rc_sel,
    input  tawas_isa_pkg::word_t    au_rc,

    input  logic                    ls_load_vld,
    input  tawas_isa_pkg::slice_t   ls_load_slice,
    input  tawas_isa_pkg::reg_sel_t ls_load_sel,
    input  tawas_isa_pkg::word_t    ls_load
);
    import tawas_isa_pkg::*;
    import tawas_bus_pkg::*;

    word_t  regs [NUM_SLICES][NUM_REGS];
    iaddr_t pc [NUM_SLICES];
    flags_t flags [NUM_SLICES];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SLICES; s++) begin
                pc[s] <= SLICE_PC_STRIDE * iaddr_t'(s);
                flags[s] <= '0;
                for (int r = 0; r < NUM_REGS; r++)
                    regs[s][r] <= '0;
            end
        end else begin
            if (pc_store)
                pc[exec_slice] <= pc_in;
            if (au_flags_upd)
                flags[exec_slice] <= au_flags_in;
            if (au_rc_vld)
                regs[exec_slice][au_rc_sel] <= au_rc;
            // Load returns one cycle late, for the previous slice
            if (ls_load_vld)
                regs[ls_load_slice][ls_load_sel] <= ls_load;
        end
    end

    assign pc_rtn = pc[slice];  // Slice being fetched
    assign au_flags = flags[exec_slice];
    assign ra = regs[exec_slice][ra_sel];
    assign rb = regs[exec_slice][rb_sel];

endmodule

`default_nettype wire

// ==== tb/tawas_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tawas port and rotation checks
// Bound into the core top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tawas_asserts (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  ics,
    input logic                  dcs,
    input logic                  dwr,
    input tawas_isa_pkg::slice_t slice
);
    import tawas_isa_pkg::*;

    int fail_count = 0;  // Failures seen so far

    // Both ports idle while in reset
    reset_idle: assert property (@(posedge clk) !arst_n |-> (!ics && !dcs))
        else begin
            fail_count++;
            $error("port strobe high during reset");
        end

    write_needs_cs: assert property (@(posedge clk) disable iff (!arst_n) dwr |-> dcs)
        else begin
            fail_count++;
            $error("dwr high without dcs");
        end

    slice_step: assert property (@(posedge clk) disable iff (!arst_n)
        1'b1 |=> (slice == slice_t'($past(slice) + 1'b1)))
        else begin
            fail_count++;
            $error("slice did not advance by one");
        end

endmodule

bind tawas tawas_asserts tawas_asserts_i (.*);

`default_nettype wire

// ==== tb/tawas_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tawas core testbench
// Memory models and a table of test programs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tawas_tb;
    import tawas_isa_pkg::*;
    import tawas_bus_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int MAX_PROG = 16;
    localparam int MAX_EXP = 16;

    logic        clk;
    logic        arst_n;
    logic        ics;
    iaddr_t      iaddr;
    word_t       idata;
    logic        dcs;
    logic        dwr;
    logic [3:0]  dmask;
    daddr_t      daddr;
    word_t       dout;
    word_t       din;

    word_t       rom [256];
    word_t       ram [256];

    // Test table
    string       test_name [NUM_TESTS];
    word_t       prog [NUM_TESTS][NUM_SLICES][MAX_PROG];
    int          prog_len [NUM_TESTS][NUM_SLICES];
    int          run_len [NUM_TESTS];
    logic [31:0] exp_addr [NUM_TESTS][MAX_EXP];
    word_t       exp_data [NUM_TESTS][MAX_EXP];
    int          exp_len [NUM_TESTS];

    int          errors = 0;
    int          checks = 0;
    int          watch_cycles = 0;
    int          cur_test = 0;  // Row being run

    tawas tawas_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Instruction ROM with one cycle of read latency
    always @(posedge clk) begin
        if (ics)
            idata <= #1 rom[iaddr[7:0]];
    end

    // Data RAM indexed by word
    always @(posedge clk) begin
        if (dcs && dwr) begin
            ram[daddr[9:2]] <= dout;
            check_value(test_name[cur_test], daddr, 32'hf, {28'h0, dmask});
        end else if (dcs) begin
            din <= #1 ram[daddr[9:2]];
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t enc(input opcode_t op, input int rc, input int ra, input int rb,
                                  input logic [15:0] imm);
        return {op, rc[2:0], ra[2:0], rb[2:0], 3'b000, imm};
    endfunction

    task automatic add_word(input int t, input int s, input word_t w);
        prog[t][s][prog_len[t][s]] = w;
        prog_len[t][s]++;
    endtask

    task automatic add_expect(input int t, input logic [31:0] a, input word_t d);
        exp_addr[t][exp_len[t]] = a;
        exp_data[t][exp_len[t]] = d;
        exp_len[t]++;
    endtask

    task automatic check_value(input string test, input logic [31:0] addr,
                               input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s addr %h expected %h actual %h", test, addr, expected, actual);
        end
    endtask

    task automatic build_table();
        logic [31:0] seed;
        logic [31:0] base;
        logic [15:0] p;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] sh;
        logic [15:0] v;
        test_name = '{"arith", "isolate", "ldst", "branch", "halt"};
        run_len = '{80, 60, 60, 160, 80};
        seed = 32'h8756_58f3;
        for (int s = 0; s < NUM_SLICES; s++) begin
            base = 32'(256 + s * 64);
            p = 16'(s * 64);
            seed = lcg_next(seed);
            a = seed[31:16];
            seed = lcg_next(seed);
            b = seed[31:16];
            seed = lcg_next(seed);
            sh = {11'b0, seed[20:16]};
            add_word(0, s, enc(LDI, 1, 0, 0, a));
            add_word(0, s, enc(LDI, 2, 0, 0, b));
            add_word(0, s, enc(LDI, 6, 0, 0, sh));
            add_word(0, s, enc(ADD, 3, 1, 2, 16'h0));
            add_word(0, s, enc(SUB, 4, 1, 2, 16'h0));
            add_word(0, s, enc(XOR, 5, 1, 2, 16'h0));
            add_word(0, s, enc(SHL, 7, 1, 6, 16'h0));
            for (int k = 0; k < 4; k++)
                add_word(0, s, enc(ST, 0, 0, (k == 3) ? 7 : k + 3, 16'(base + 4 * k)));
            add_word(0, s, enc(HALT, 0, 0, 0, 16'h0));
            add_expect(0, base, sext16(a) + sext16(b));
            add_expect(0, base + 4, sext16(a) - sext16(b));
            add_expect(0, base + 8, sext16(a) ^ sext16(b));
            add_expect(0, base + 12, sext16(a) << sh[4:0]);

            // Same registers in every slice with different values
            v = 16'(32'h1000 * (s + 1));
            add_word(1, s, enc(LDI, 1, 0, 0, v));
            add_word(1, s, enc(LDI, 2, 0, 0, 16'(s + 7)));
            add_word(1, s, enc(ADD, 3, 1, 2, 16'h0));
            add_word(1, s, enc(ST, 0, 0, 1, base[15:0]));
            add_word(1, s, enc(ST, 0, 0, 3, 16'(base + 4)));
            add_word(1, s, enc(HALT, 0, 0, 0, 16'h0));
            add_expect(1, base, sext16(v));
            add_expect(1, base + 4, sext16(v) + 32'(s + 7));

            v = 16'(32'h05a5 + s * 32'h3000);  // Slice 3 gets a negative value
            add_word(2, s, enc(LDI, 1, 0, 0, v));
            add_word(2, s, enc(ST, 0, 0, 1, base[15:0]));
            add_word(2, s, enc(LD, 2, 0, 0, base[15:0]));
            add_word(2, s, enc(LDI, 3, 0, 0, 16'h1));
            add_word(2, s, enc(ADD, 4, 2, 3, 16'h0));
            add_word(2, s, enc(ST, 0, 0, 4, 16'(base + 4)));
            add_word(2, s, enc(HALT, 0, 0, 0, 16'h0));
            add_expect(2, base, sext16(v));
            add_expect(2, base + 4, sext16(v) + 32'd1);

            // Countdown of s+3 where BZ falls through on the reset flags
            add_word(3, s, enc(LDI, 1, 0, 0, 16'(s + 3)));
            add_word(3, s, enc(LDI, 2, 0, 0, 16'h1));
            add_word(3, s, enc(BZ, 0, 0, 0, p + 16'd11));
            add_word(3, s, enc(ADD, 3, 3, 2, 16'h0));
            add_word(3, s, enc(SUB, 1, 1, 2, 16'h0));
            add_word(3, s, enc(BNZ, 0, 0, 0, p + 16'd3));
            add_word(3, s, enc(ST, 0, 0, 1, base[15:0]));
            add_word(3, s, enc(ST, 0, 0, 3, 16'(base + 4)));
            add_word(3, s, enc(JMP, 0, 0, 0, p + 16'd10));
            add_word(3, s, enc(ST, 0, 0, 2, 16'(base + 12)));  // Skipped by the JMP
            add_word(3, s, enc(ST, 0, 0, 2, 16'(base + 8)));
            add_word(3, s, enc(HALT, 0, 0, 0, 16'h0));
            add_expect(3, base, 32'd0);
            add_expect(3, base + 4, 32'(s + 3));
            add_expect(3, base + 8, 32'd1);
            add_expect(3, base + 12, 32'd0);

            v = 16'(32'h0a00 + s);
            add_word(4, s, enc(LDI, 1, 0, 0, v));
            for (int k = 0; k < 3 * s; k++)
                add_word(4, s, enc(NOP, 0, 0, 0, 16'h0));
            add_word(4, s, enc(ST, 0, 0, 1, base[15:0]));
            add_word(4, s, enc(HALT, 0, 0, 0, 16'h0));
            add_word(4, s, enc(ST, 0, 0, 1, 16'(base + 4)));
            add_word(4, s, enc(ST, 0, 0, 1, 16'(base + 8)));
            add_expect(4, base, sext16(v));
            add_expect(4, base + 4, 32'd0);
            add_expect(4, base + 8, 32'd0);
        end
    endtask

    task automatic run_test(input int t);
        int errs_before;
        errs_before = errors;
        cur_test = t;
        @(posedge clk);
        #1 arst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = '0;
            ram[i] = '0;
        end
        for (int s = 0; s < NUM_SLICES; s++)
            for (int k = 0; k < prog_len[t][s]; k++)
                rom[s * SLICE_PC_STRIDE + k] = prog[t][s][k];
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (run_len[t]) @(posedge clk);
        #1;
        for (int j = 0; j < exp_len[t]; j++)
            check_value(test_name[t], exp_addr[t][j], exp_data[t][j],
                        ram[exp_addr[t][j][9:2]]);
        $display("test %-8s %0d checks, %0d errors", test_name[t], exp_len[t],
                 errors - errs_before);
    endtask

    initial begin
        int total;
        arst_n = 1'b1;
        idata = '0;
        din = '0;
        build_table();
        total = 100;
        for (int t = 0; t < NUM_TESTS; t++)
            total += run_len[t];
        watch_cycles = total;
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        total = errors + tawas_i.tawas_asserts_i.fail_count;
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, total);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watch_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
